//--- include/decode_cfg.svh
// Configuration macros for the decode and issue stage
// Sequence number width, register count, pipe count

`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// --------------------------------------------------
// Program order tracking
// --------------------------------------------------

// Width of the sequence number carried from fetch
`define SEQ_NUM_BITS 8

// --------------------------------------------------
// Architectural state and execute resources
// --------------------------------------------------

// Architectural integer registers, x0 included
`define NUM_REGS 32

// One pipe per unit class
// Pipe 0 is ALU/branch, pipe 1 is multiply/memory
`define NUM_PIPES 2

`endif

//--- hw/decode_pkg.sv
// Shared types for the decode and issue stage
// Vector typedefs, uop/unit/immediate enums, channel structs

`default_nettype none

`include "decode_cfg.svh"

package decode_pkg;

  // --------------------------------------------------
  // Plain vector types
  // --------------------------------------------------

  typedef logic [31:0]               inst_t;
  typedef logic [31:0]               data_t;
  typedef logic [4:0]                reg_addr_t;
  typedef logic [`SEQ_NUM_BITS-1:0] seq_num_t;

  // TinyRV1 operations
  typedef enum logic [2:0] {
    UOP_ADD,
    UOP_ADDI,
    UOP_MUL,
    UOP_LW,
    UOP_SW,
    UOP_JAL,
    UOP_JR,
    UOP_BNE
  } uop_e;

  // Unit class, value doubles as the pipe index
  typedef enum logic [$clog2(`NUM_PIPES)-1:0] {
    UNIT_ALU    = 0,
    UNIT_MULMEM = 1
  } unit_e;

  // Immediate formats
  typedef enum logic [1:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_J
  } imm_e;

  // --------------------------------------------------
  // Channel and internal structs
  // --------------------------------------------------

  // Fetch to decode
  typedef struct packed {
    inst_t    inst;
    data_t    pc;
    seq_num_t seq_num;
  } fetch_pkt_t;

  // Decode to execute pipes, shared by both pipes
  typedef struct packed {
    data_t     pc;
    uop_e      uop;
    data_t     op1;
    data_t     op2;
    reg_addr_t waddr;
    seq_num_t  seq_num;
  } issue_pkt_t;

  // Writeback strobe from the pipes
  typedef struct packed {
    logic      wen;
    reg_addr_t waddr;
    data_t     wdata;
    seq_num_t  seq_num;
  } complete_pkt_t;

  // Decoder result
  typedef struct packed {
    uop_e      uop;
    unit_e     unit;
    reg_addr_t raddr0;
    reg_addr_t raddr1;
    logic      ren0;
    logic      ren1;
    reg_addr_t waddr;
    logic      wen;
    logic      op2_imm;
    data_t     imm;
  } decode_t;

endpackage

`default_nettype wire

//--- hw/inst_decoder.sv
// TinyRV1 instruction decoder
// Uop, unit class, register fields, enables and immediate

`default_nettype none

module inst_decoder (
  input  decode_pkg::inst_t   inst,
  output decode_pkg::decode_t dec,
  output logic                dec_val
);

  // Major opcodes used by TinyRV1
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  decode_pkg::reg_addr_t   rs1;
  decode_pkg::reg_addr_t   rs2;
  decode_pkg::reg_addr_t   rd;
  decode_pkg::uop_e        uop;
  decode_pkg::unit_e       unit;
  decode_pkg::imm_e        imm_sel;
  logic                    ren0;
  logic                    ren1;
  logic                    wen_raw;
  logic                    wen;
  logic                    op2_imm;
  decode_pkg::data_t       imm;

  // Standard RV32 field positions
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  // --------------------------------------------------
  // Opcode and function decode
  // --------------------------------------------------

  always_comb begin
    dec_val = 1'b1;
    uop     = decode_pkg::UOP_ADD;
    unit    = decode_pkg::UNIT_ALU;
    imm_sel = decode_pkg::IMM_I;
    ren0    = 1'b0;
    ren1    = 1'b0;
    wen_raw = 1'b0;
    op2_imm = 1'b0;
    case (opcode)
      OPC_OP: begin
        ren0    = 1'b1;
        ren1    = 1'b1;
        wen_raw = 1'b1;
        // add and mul share opcode and funct3
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          uop = decode_pkg::UOP_ADD;
        end else if (funct3 == 3'b000 && funct7 == 7'b0000001) begin
          uop  = decode_pkg::UOP_MUL;
          unit = decode_pkg::UNIT_MULMEM;
        end else begin
          dec_val = 1'b0;
        end
      end
      OPC_OP_IMM: begin
        uop     = decode_pkg::UOP_ADDI;
        ren0    = 1'b1;
        wen_raw = 1'b1;
        op2_imm = 1'b1;
        dec_val = (funct3 == 3'b000);
      end
      OPC_LOAD: begin
        uop     = decode_pkg::UOP_LW;
        unit    = decode_pkg::UNIT_MULMEM;
        ren0    = 1'b1;
        wen_raw = 1'b1;
        op2_imm = 1'b1;
        dec_val = (funct3 == 3'b010);
      end
      OPC_STORE: begin
        // Base in op1 and offset in op2
        uop     = decode_pkg::UOP_SW;
        unit    = decode_pkg::UNIT_MULMEM;
        imm_sel = decode_pkg::IMM_S;
        ren0    = 1'b1;
        ren1    = 1'b1;
        op2_imm = 1'b1;
        dec_val = (funct3 == 3'b010);
      end
      OPC_JAL: begin
        uop     = decode_pkg::UOP_JAL;
        imm_sel = decode_pkg::IMM_J;
        wen_raw = 1'b1;
        op2_imm = 1'b1;
      end
      OPC_JALR: begin
        // Only the jr form with rd = x0 and zero offset
        uop     = decode_pkg::UOP_JR;
        ren0    = 1'b1;
        dec_val = (funct3 == 3'b000) && (rd == '0) && (inst[31:20] == '0);
      end
      OPC_BRANCH: begin
        uop     = decode_pkg::UOP_BNE;
        imm_sel = decode_pkg::IMM_B;
        ren0    = 1'b1;
        ren1    = 1'b1;
        dec_val = (funct3 == 3'b001);
      end
      default: dec_val = 1'b0;
    endcase
  end

  // --------------------------------------------------
  // Sign-extended immediate generation
  // --------------------------------------------------

  always_comb begin
    case (imm_sel)
      decode_pkg::IMM_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      decode_pkg::IMM_B: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                inst[11:8], 1'b0};
      decode_pkg::IMM_J: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                inst[30:21], 1'b0};
      default:           imm = {{20{inst[31]}}, inst[31:20]};
    endcase
  end

  // Writes to x0 are dropped here
  assign wen = wen_raw && (rd != '0);

  // Unused read ports point at x0 so they read zero, never pending
  always_comb begin
    dec.uop     = uop;
    dec.unit    = unit;
    dec.raddr0  = ren0 ? rs1 : '0;
    dec.raddr1  = ren1 ? rs2 : '0;
    dec.ren0    = ren0;
    dec.ren1    = ren1;
    dec.waddr   = wen ? rd : '0;
    dec.wen     = wen;
    dec.op2_imm = op2_imm;
    dec.imm     = imm;
  end

endmodule

`default_nettype wire

//--- hw/regfile_pending.sv
// Register file with a pending-write bit per register
// Two read ports, completion write port, pending-set port

`default_nettype none

`include "decode_cfg.svh"

module regfile_pending (
  input  logic                      clk,
  input  logic                      rst,
  input  decode_pkg::reg_addr_t     raddr0,
  input  decode_pkg::reg_addr_t     raddr1,
  output decode_pkg::data_t         rdata0,
  output decode_pkg::data_t         rdata1,
  output logic                      rpending0,
  output logic                      rpending1,
  input  decode_pkg::reg_addr_t     check_addr,
  output logic                      check_pending,
  input  logic                      complete_val,
  input  decode_pkg::complete_pkt_t complete,
  input  logic                      set_val,
  input  decode_pkg::reg_addr_t     set_addr
);

  decode_pkg::data_t      regs [`NUM_REGS];
  logic [`NUM_REGS-1:0]   pending;
  logic                   wr_en;
  logic                   set_en;

  // x0 is never written and never marked
  assign wr_en  = complete_val && complete.wen && (complete.waddr != '0);
  assign set_en = set_val && (set_addr != '0);

  // --------------------------------------------------
  // State update
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr_en) begin
        regs[complete.waddr]    <= complete.wdata;
        pending[complete.waddr] <= 1'b0;
      end
      // Later assignment, so a same-edge set beats the clear
      if (set_en) begin
        pending[set_addr] <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Read side, no bypass from the completion port
  // --------------------------------------------------

  // x0 reads as zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // pending[0] stays clear since set_en excludes x0
  assign rpending0     = pending[raddr0];
  assign rpending1     = pending[raddr1];
  assign check_pending = pending[check_addr];

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Each completion must match an earlier issue that marked its register
  assert property (@(posedge clk) disable iff (rst)
    wr_en |-> pending[complete.waddr])
    else $error("completion to x%0d which is not pending", complete.waddr);

endmodule

`default_nettype wire

//--- hw/issue_router.sv
// Issue router
// Hazard stall, operand select, per-pipe valid and transfer

`default_nettype none

`include "decode_cfg.svh"

module issue_router (
  input  logic                        held_val,
  input  decode_pkg::decode_t         dec,
  input  logic                        dec_val,
  input  decode_pkg::data_t           rdata0,
  input  decode_pkg::data_t           rdata1,
  input  logic                        rpending0,
  input  logic                        rpending1,
  input  logic                        wpending,
  input  decode_pkg::data_t           pc,
  input  decode_pkg::seq_num_t        seq_num,
  output logic [`NUM_PIPES-1:0]       issue_val,
  input  logic [`NUM_PIPES-1:0]       issue_rdy,
  output decode_pkg::issue_pkt_t      issue,
  output logic                        issue_xfer
);

  logic raw_stall;
  logic waw_stall;
  logic stall;
  logic go;

  // --------------------------------------------------
  // Hazard detection
  // --------------------------------------------------

  // RAW on a used source
  assign raw_stall = (dec.ren0 && rpending0) || (dec.ren1 && rpending1);
  // WAW on the destination
  assign waw_stall = dec.wen && wpending;
  assign stall     = raw_stall || waw_stall;

  // Illegal encodings never leave the held register
  assign go = held_val && dec_val && !stall;

  // --------------------------------------------------
  // Pipe select and handshake
  // --------------------------------------------------

  // Unit class value is the pipe index
  assign issue_val  = go ? (`NUM_PIPES'(1) << dec.unit) : '0;
  assign issue_xfer = |(issue_val & issue_rdy);

  // Packet shared by all pipes
  always_comb begin
    issue.pc      = pc;
    issue.uop     = dec.uop;
    issue.op1     = rdata0;
    issue.op2     = dec.op2_imm ? dec.imm : rdata1;
    issue.waddr   = dec.waddr;
    issue.seq_num = seq_num;
  end

endmodule

`default_nettype wire

//--- hw/decode_issue_unit.sv
// Decode and issue stage top level
// Held fetch register, decoder, pending regfile, router

`default_nettype none

`include "decode_cfg.svh"

module decode_issue_unit (
  input  logic                      clk,
  input  logic                      rst,

  // Fetch channel
  input  logic                      fetch_val,
  output logic                      fetch_rdy,
  input  decode_pkg::fetch_pkt_t    fetch,

  // Issue channels
  output logic [`NUM_PIPES-1:0]     issue_val,
  input  logic [`NUM_PIPES-1:0]     issue_rdy,
  output decode_pkg::issue_pkt_t    issue,

  // Completion strobe
  input  logic                      complete_val,
  input  decode_pkg::complete_pkt_t complete
);

  decode_pkg::fetch_pkt_t held;
  logic                   held_val;
  logic                   fetch_xfer;
  logic                   issue_xfer;
  decode_pkg::decode_t    dec;
  logic                   dec_val;
  decode_pkg::data_t      rdata0;
  decode_pkg::data_t      rdata1;
  logic                   rpending0;
  logic                   rpending1;
  logic                   wpending;

  // --------------------------------------------------
  // Held fetch register
  // --------------------------------------------------

  // Accept when empty or when the held one leaves this cycle
  assign fetch_rdy  = !held_val || issue_xfer;
  assign fetch_xfer = fetch_val && fetch_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_val <= 1'b0;
    end else if (fetch_xfer) begin
      held_val <= 1'b1;
    end else if (issue_xfer) begin
      held_val <= 1'b0;
    end
  end

  // Packet loads with each accepted fetch
  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      held <= fetch;
    end
  end

  // --------------------------------------------------
  // Decode and register read side by side
  // --------------------------------------------------

  inst_decoder inst_decoder_inst (
    .inst    (held.inst),
    .dec     (dec),
    .dec_val (dec_val)
  );

  // Issued destination becomes pending at the transfer edge
  regfile_pending regfile_pending_inst (
    .clk           (clk),
    .rst           (rst),
    .raddr0        (dec.raddr0),
    .raddr1        (dec.raddr1),
    .rdata0        (rdata0),
    .rdata1        (rdata1),
    .rpending0     (rpending0),
    .rpending1     (rpending1),
    .check_addr    (dec.waddr),
    .check_pending (wpending),
    .complete_val  (complete_val),
    .complete      (complete),
    .set_val       (issue_xfer && dec.wen),
    .set_addr      (dec.waddr)
  );

  issue_router issue_router_inst (
    .held_val   (held_val),
    .dec        (dec),
    .dec_val    (dec_val),
    .rdata0     (rdata0),
    .rdata1     (rdata1),
    .rpending0  (rpending0),
    .rpending1  (rpending1),
    .wpending   (wpending),
    .pc         (held.pc),
    .seq_num    (held.seq_num),
    .issue_val  (issue_val),
    .issue_rdy  (issue_rdy),
    .issue      (issue),
    .issue_xfer (issue_xfer)
  );

  // Held instruction stays put until it issues
  assert property (@(posedge clk) disable iff (rst)
    (held_val && !issue_xfer) |=> (held_val && $stable(held)))
    else $error("held packet changed before issue");

endmodule

`default_nettype wire

//--- verif/decode_issue_checker.sv
// Checker for the decode and issue stage
// Reset values, issue order and fields, hazards, back-pressure

`default_nettype none

`include "decode_cfg.svh"

module decode_issue_checker #(
  parameter int NUM_ENTRIES = 1
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fetch_val,
  input  logic                      fetch_rdy,
  input  decode_pkg::fetch_pkt_t    fetch,
  input  logic [`NUM_PIPES-1:0]     issue_val,
  input  logic [`NUM_PIPES-1:0]     issue_rdy,
  input  decode_pkg::issue_pkt_t    issue,
  input  logic                      complete_val,
  input  decode_pkg::complete_pkt_t complete,
  input  decode_pkg::issue_pkt_t    exp_pkts [NUM_ENTRIES],
  input  logic                      exp_pipes [NUM_ENTRIES],
  output int                        error_count,
  output int                        issued_count
);

  // Registers with a write in flight, as seen on the ports
  logic [`NUM_REGS-1:0]   pend = '0;
  decode_pkg::inst_t      inst_q [$];
  logic                   rst_q = 1'b0;
  logic                   stalled_q = 1'b0;
  logic [`NUM_PIPES-1:0]  val_q;
  decode_pkg::issue_pkt_t pkt_q;
  logic                   fire;

  initial begin
    error_count  = 0;
    issued_count = 0;
  end

  task automatic report_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
    $display("[ERROR] %s: expected 0x%08h, got 0x%08h (seq %0d)", name, want, got,
             issued_count);
    error_count++;
  endtask

  // Pipe and packet fields against the table row
  task automatic compare_issue(input int idx);
    decode_pkg::issue_pkt_t want;
    logic [`NUM_PIPES-1:0]  want_val;
    want     = exp_pkts[idx];
    want_val = `NUM_PIPES'(1) << exp_pipes[idx];
    if (issue_val !== want_val) report_mismatch("issue_val", 32'(want_val), 32'(issue_val));
    if (issue.pc !== want.pc) report_mismatch("issue.pc", want.pc, issue.pc);
    if (issue.uop !== want.uop) report_mismatch("issue.uop", 32'(want.uop), 32'(issue.uop));
    if (issue.op1 !== want.op1) report_mismatch("issue.op1", want.op1, issue.op1);
    if (issue.op2 !== want.op2) report_mismatch("issue.op2", want.op2, issue.op2);
    if (issue.waddr !== want.waddr) begin
      report_mismatch("issue.waddr", 32'(want.waddr), 32'(issue.waddr));
    end
    if (issue.seq_num !== want.seq_num) begin
      report_mismatch("issue.seq_num", 32'(want.seq_num), 32'(issue.seq_num));
    end
  endtask

  // Sources come from the ISA fields of the fetched word
  task automatic check_hazards(input decode_pkg::inst_t inst);
    decode_pkg::reg_addr_t rs1;
    decode_pkg::reg_addr_t rs2;
    logic                  use1;
    logic                  use2;
    rs1  = inst[19:15];
    rs2  = inst[24:20];
    use1 = (issue.uop != decode_pkg::UOP_JAL);
    use2 = issue.uop inside {decode_pkg::UOP_ADD, decode_pkg::UOP_MUL,
                             decode_pkg::UOP_SW, decode_pkg::UOP_BNE};
    if ((use1 && pend[rs1]) || (use2 && pend[rs2]) || pend[issue.waddr]) begin
      $display("Hazard: seq %0d issued while one of its registers still waits on a write",
               issued_count);
      error_count++;
    end
  endtask

  always @(posedge clk) begin
    // Reset state, during reset and one edge after
    if (rst_q) begin
      if (issue_val !== '0) report_mismatch("issue_val", 32'd0, 32'(issue_val));
      if (fetch_rdy !== 1'b1) report_mismatch("fetch_rdy", 32'd1, 32'(fetch_rdy));
    end
    if (!rst) begin
      fire = |(issue_val & issue_rdy);
      // Stalled offer must hold still
      if (stalled_q && (issue_val !== val_q || issue !== pkt_q)) begin
        $display("Back-pressure: issue_val or the issue packet changed while stalled");
        error_count++;
      end
      if (|issue_val && !fire && fetch_rdy !== 1'b0) begin
        report_mismatch("fetch_rdy", 32'd0, 32'(fetch_rdy));
      end
      if (fetch_val && fetch_rdy) begin
        inst_q.push_back(fetch.inst);
      end
      if (fire) begin
        if (issued_count >= NUM_ENTRIES || inst_q.size() == 0) begin
          $display("Extra issue: seq %0d was never fetched or issued twice", issue.seq_num);
          error_count++;
        end else begin
          compare_issue(issued_count);
          check_hazards(inst_q.pop_front());
        end
        issued_count++;
      end
      // Clear before set, same order as the register file
      if (complete_val && complete.wen) begin
        pend[complete.waddr] = 1'b0;
      end
      if (fire && issue.waddr != '0) begin
        pend[issue.waddr] = 1'b1;
      end
      stalled_q = |issue_val && !fire;
      val_q     = issue_val;
      pkt_q     = issue;
    end else begin
      stalled_q = 1'b0;
    end
    rst_q = rst;
  end

endmodule

`default_nettype wire

//--- verif/decode_issue_tb.sv
// Testbench top for the decode and issue stage
// Clock, reset, instruction table, fetch driver, pipe models, watchdog

`default_nettype none

`include "decode_cfg.svh"

module decode_issue_tb;

  localparam int NUM_ENTRIES     = 16;
  localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 40;

  // One table row, stimulus plus the expected issue packet
  typedef struct packed {
    decode_pkg::inst_t      inst;
    logic                   pipe;
    decode_pkg::issue_pkt_t pkt;
    decode_pkg::data_t      result;
  } entry_t;

  logic                      clk;
  logic                      rst;
  logic                      fetch_val;
  logic                      fetch_rdy;
  decode_pkg::fetch_pkt_t    fetch;
  logic [`NUM_PIPES-1:0]     issue_val;
  logic [`NUM_PIPES-1:0]     issue_rdy;
  decode_pkg::issue_pkt_t    issue;
  logic                      complete_val;
  decode_pkg::complete_pkt_t complete;

  entry_t                    tbl [NUM_ENTRIES];
  decode_pkg::issue_pkt_t    exp_pkts [NUM_ENTRIES];
  logic                      exp_pipes [NUM_ENTRIES];
  int                        num_added;
  int                        error_count;
  int                        issued_count;
  int                        seed = 32'h3a44_73a7;
  int                        cycle;

  // Edge samples used by the negedge drivers
  logic                      fetch_fire;
  logic [`NUM_PIPES-1:0]     issue_fire;
  decode_pkg::issue_pkt_t    fired_pkt;

  // Completions waiting for their delay to run out
  int                        due_q [$];
  decode_pkg::complete_pkt_t cpl_q [$];

  // --------------------------------------------------
  // DUT and checker
  // --------------------------------------------------

  decode_issue_unit decode_issue_unit_inst (
    .clk          (clk),
    .rst          (rst),
    .fetch_val    (fetch_val),
    .fetch_rdy    (fetch_rdy),
    .fetch        (fetch),
    .issue_val    (issue_val),
    .issue_rdy    (issue_rdy),
    .issue        (issue),
    .complete_val (complete_val),
    .complete     (complete)
  );

  decode_issue_checker #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) decode_issue_checker_inst (
    .clk          (clk),
    .rst          (rst),
    .fetch_val    (fetch_val),
    .fetch_rdy    (fetch_rdy),
    .fetch        (fetch),
    .issue_val    (issue_val),
    .issue_rdy    (issue_rdy),
    .issue        (issue),
    .complete_val (complete_val),
    .complete     (complete),
    .exp_pkts     (exp_pkts),
    .exp_pipes    (exp_pipes),
    .error_count  (error_count),
    .issued_count (issued_count)
  );

  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_expect
    assign exp_pkts[i]  = tbl[i].pkt;
    assign exp_pipes[i] = tbl[i].pipe;
  end

  // Period 8
  initial clk = 1'b0;
  always #4 clk = ~clk;

  // --------------------------------------------------
  // Instruction encoders, RV32 field layout
  // --------------------------------------------------

  // add / mul
  function automatic decode_pkg::inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, 7'h33};
  endfunction

  // addi / lw / jr
  function automatic decode_pkg::inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // sw
  function automatic decode_pkg::inst_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  // bne, offset bit 0 is implied
  function automatic decode_pkg::inst_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'h63};
  endfunction

  // jal
  function automatic decode_pkg::inst_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // --------------------------------------------------
  // Table, pc and seq_num follow the row index
  // --------------------------------------------------

  task automatic add_entry(input decode_pkg::inst_t inst, input logic pipe,
                           input decode_pkg::uop_e uop, input decode_pkg::data_t op1,
                           input decode_pkg::data_t op2, input decode_pkg::reg_addr_t waddr,
                           input decode_pkg::data_t result);
    entry_t e;
    e.inst        = inst;
    e.pipe        = pipe;
    e.pkt.pc      = 32'h200 + 32'(num_added * 4);
    e.pkt.uop     = uop;
    e.pkt.op1     = op1;
    e.pkt.op2     = op2;
    e.pkt.waddr   = waddr;
    e.pkt.seq_num = `SEQ_NUM_BITS'(num_added);
    e.result      = result;
    tbl[num_added] = e;
    num_added++;
  endtask

  // Operands by hand, registers start at zero
  task automatic fill_table();
    // addi x1, x0, 5 then RAW on x1
    add_entry(i_type(12'h005, 5'd0, 3'b000, 5'd1, 7'h13), 1'b0, decode_pkg::UOP_ADDI,
              32'h0, 32'h5, 5'd1, 32'h5);
    add_entry(i_type(12'hffd, 5'd1, 3'b000, 5'd2, 7'h13), 1'b0, decode_pkg::UOP_ADDI,
              32'h5, 32'hffff_fffd, 5'd2, 32'h2);
    add_entry(r_type(7'h00, 5'd2, 5'd1, 5'd3), 1'b0, decode_pkg::UOP_ADD,
              32'h5, 32'h2, 5'd3, 32'h7);
    // mul pair, WAW on x4
    add_entry(r_type(7'h01, 5'd2, 5'd3, 5'd4), 1'b1, decode_pkg::UOP_MUL,
              32'h7, 32'h2, 5'd4, 32'he);
    add_entry(r_type(7'h01, 5'd1, 5'd1, 5'd4), 1'b1, decode_pkg::UOP_MUL,
              32'h5, 32'h5, 5'd4, 32'h19);
    // sw x4, -8(x2)
    add_entry(s_type(12'hff8, 5'd4, 5'd2), 1'b1, decode_pkg::UOP_SW,
              32'h2, 32'hffff_fff8, 5'd0, 32'h0);
    add_entry(i_type(12'h00c, 5'd4, 3'b010, 5'd5, 7'h03), 1'b1, decode_pkg::UOP_LW,
              32'h19, 32'hc, 5'd5, 32'h1234);
    // bne carries rs2 as op2
    add_entry(b_type(13'h1ff0, 5'd3, 5'd5), 1'b0, decode_pkg::UOP_BNE,
              32'h1234, 32'h7, 5'd0, 32'h0);
    add_entry(j_type(21'h1f_ffec, 5'd6), 1'b0, decode_pkg::UOP_JAL,
              32'h0, 32'hffff_ffec, 5'd6, 32'h224);
    add_entry(i_type(12'h000, 5'd6, 3'b000, 5'd0, 7'h67), 1'b0, decode_pkg::UOP_JR,
              32'h224, 32'h0, 5'd0, 32'h0);
    // Destination x0 is dropped
    add_entry(i_type(12'h064, 5'd1, 3'b000, 5'd0, 7'h13), 1'b0, decode_pkg::UOP_ADDI,
              32'h5, 32'h64, 5'd0, 32'h0);
    add_entry(r_type(7'h00, 5'd6, 5'd0, 5'd7), 1'b0, decode_pkg::UOP_ADD,
              32'h0, 32'h224, 5'd7, 32'h224);
    // lw x1 then add x1, x1, x1 (RAW and WAW)
    add_entry(i_type(12'hffc, 5'd7, 3'b010, 5'd1, 7'h03), 1'b1, decode_pkg::UOP_LW,
              32'h224, 32'hffff_fffc, 5'd1, 32'h55aa);
    add_entry(r_type(7'h00, 5'd1, 5'd1, 5'd1), 1'b0, decode_pkg::UOP_ADD,
              32'h55aa, 32'h55aa, 5'd1, 32'hab54);
    add_entry(i_type(12'h7ff, 5'd1, 3'b000, 5'd8, 7'h13), 1'b0, decode_pkg::UOP_ADDI,
              32'hab54, 32'h7ff, 5'd8, 32'hb353);
    add_entry(s_type(12'h7f4, 5'd8, 5'd0), 1'b1, decode_pkg::UOP_SW,
              32'h0, 32'h7f4, 5'd0, 32'h0);
  endtask

  // --------------------------------------------------
  // Fetch driver and pipe models
  // --------------------------------------------------

  // Handshake outcome of each rising edge
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_fire <= 1'b0;
      issue_fire <= '0;
    end else begin
      fetch_fire <= fetch_val && fetch_rdy;
      issue_fire <= issue_val & issue_rdy;
    end
    fired_pkt <= issue;
  end

  // Packet held until the edge that takes it
  task automatic drive_fetch();
    int idx;
    idx = 0;
    while (idx < NUM_ENTRIES) begin
      @(negedge clk);
      if (fetch_fire) begin
        idx++;
      end
      if (idx < NUM_ENTRIES) begin
        fetch_val     = 1'b1;
        fetch.inst    = tbl[idx].inst;
        fetch.pc      = tbl[idx].pkt.pc;
        fetch.seq_num = tbl[idx].pkt.seq_num;
      end else begin
        fetch_val = 1'b0;
      end
    end
  endtask

  // Random ready, completion 1 to 6 edges after acceptance
  always @(negedge clk) begin : pipe_model
    decode_pkg::complete_pkt_t cpl;
    int pick;
    int row;
    cycle++;
    if (issue_fire != '0) begin
      row           = int'(fired_pkt.seq_num);
      cpl.wen       = (fired_pkt.waddr != '0);
      cpl.waddr     = fired_pkt.waddr;
      cpl.wdata     = tbl[row].result;
      cpl.seq_num   = fired_pkt.seq_num;
      due_q.push_back(cycle + int'($unsigned($random(seed)) % 6));
      cpl_q.push_back(cpl);
    end
    complete_val = 1'b0;
    pick = -1;
    for (int i = 0; i < due_q.size(); i++) begin
      if (pick < 0 && due_q[i] <= cycle) begin
        pick = i;
      end
    end
    // One completion per cycle, oldest due first
    if (pick >= 0) begin
      complete_val = 1'b1;
      complete     = cpl_q[pick];
      due_q.delete(pick);
      cpl_q.delete(pick);
    end
    issue_rdy[0] = ($random(seed) & 3) != 0;
    issue_rdy[1] = ($random(seed) & 3) != 0;
  end

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------

  initial begin
    rst          = 1'b1;
    fetch_val    = 1'b0;
    fetch        = '0;
    issue_rdy    = '0;
    complete_val = 1'b0;
    complete     = '0;
    cycle        = 0;
    num_added    = 0;
    fill_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    drive_fetch();
    while (issued_count < NUM_ENTRIES) begin
      @(negedge clk);
    end
    // Let the last completions land
    repeat (8) @(negedge clk);
    $display("Closing: %0d errors, %0d of %0d instructions issued",
             error_count, issued_count, NUM_ENTRIES);
    if (error_count == 0 && issued_count == NUM_ENTRIES) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: issue stalled, %0d of %0d instructions issued in %0d cycles",
             issued_count, NUM_ENTRIES, WATCHDOG_CYCLES);
    $display("Closing: %0d errors", error_count);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
hw/decode_pkg.sv
hw/inst_decoder.sv
hw/regfile_pending.sv
hw/issue_router.sv
hw/decode_issue_unit.sv
verif/decode_issue_checker.sv
verif/decode_issue_tb.sv

//--- Makefile
# Verilator build and run for the decode and issue stage

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := decode_issue_tb
FILELIST := build.f
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
